//--- filelist.f
rtl/csa_pkg.sv
rtl/lane_result_if.sv
rtl/job_fifo.sv
rtl/key_search_core.sv
rtl/search_lane.sv
rtl/result_store.sv
rtl/wb_host_regs.sv
rtl/csa_search_top.sv
tb/csa_search_asserts.sv
tb/tb_csa_search.sv

//--- tb/tb_csa_search.sv
`default_nettype none

module tb_csa_search import csa_pkg::*; ();

	localparam int CLK_PERIOD     = 100;
	localparam int DRIVE_DLY      = 5;
	localparam int RESET_CYCLES   = 8;
	localparam int TIMEOUT_CYCLES = 20000; // about 1700 candidates in all, plus bus traffic

	logic              clk;
	logic              rst_n;
	logic              wb_cyc;
	logic              wb_stb;
	logic              wb_we;
	logic [ADDR_W-1:0] wb_adr;
	logic [WORD_W-1:0] wb_dat_w;
	logic [3:0]        wb_sel;
	logic [WORD_W-1:0] wb_dat;
	logic              wb_ack;
	int unsigned       cycles;

	csa_search_top dut0 (
		.clk      (clk),
		.rst_n    (rst_n),
		.wb_cyc_i (wb_cyc),
		.wb_stb_i (wb_stb),
		.wb_we_i  (wb_we),
		.wb_adr_i (wb_adr),
		.wb_dat_i (wb_dat_w),
		.wb_sel_i (wb_sel),
		.wb_dat_o (wb_dat),
		.wb_ack_o (wb_ack)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
		$display("Test failed");
		$fatal(1, "run stopped by the cycle limit");
	end

	initial begin
		wait (dut0.u_asserts.fail_count != 0);
		$display("A bound assertion on the bus or the arbiter failed");
		$display("Test failed");
		$fatal(1, "assertion failure");
	end

	// reference for the mixing rule, rotate left by 11 written as two shifts
	function automatic logic [CIPHER_W-1:0] mix_ref(input logic [CIPHER_W-1:0] in,
			input logic [WORD_W-1:0] k);
		logic [CIPHER_W-1:0] s;
		s = in ^ {k, ~k};
		for (int r = 0; r < MIX_ROUNDS; r++) begin
			s = ((s << 11) | (s >> 53)) ^ (s >> 5) ^ MIX_CONST;
		end
		return s;
	endfunction

	// record words as the host should read them back
	function automatic logic [3:0][WORD_W-1:0] search_ref(input job_t j, input logic lane);
		logic [3:0][WORD_W-1:0] w;
		logic [WORD_W-1:0]      c;
		logic [WORD_W-1:0]      k;
		logic                   hit;
		w[0] = j.block;
		w[1] = '0;
		w[2] = {30'b0, lane, 1'b0};
		w[3] = j.times;
		c    = '0;
		hit  = 1'b0;
		while (!hit && c < j.times) begin
			k = j.times_start + c;
			if (((mix_ref(j.cipher_in, k) ^ j.value) & j.mask) == '0) begin
				hit  = 1'b1;
				w[1] = k;
				w[2][0] = 1'b1;
				w[3] = c + 1;
			end
			c++;
		end
		return w;
	endfunction

	function automatic job_t random_job(input logic [SLOT_W-1:0] slot);
		job_t j;
		j.block       = ($urandom() & ~32'h7) | WORD_W'(slot); // low bits pick the result slot
		j.cipher_in   = {$urandom(), $urandom()};
		j.mask        = '1;
		j.value       = {$urandom(), $urandom()};
		j.times_start = $urandom();
		j.times       = 32'd200;
		return j;
	endfunction

	task automatic check_eq(input string name, input logic [WORD_W-1:0] expected,
			input logic [WORD_W-1:0] actual);
		assert (actual === expected) else begin
			$display("Error: %s expected %h actual %h", name, expected, actual);
			$display("Test failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic wb_write(input logic [ADDR_W-1:0] addr, input logic [WORD_W-1:0] data);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = 1'b1;
		wb_adr   = addr;
		wb_dat_w = data;
		do begin
			@(posedge clk);
			#DRIVE_DLY;
		end while (!wb_ack);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic wb_read(input logic [ADDR_W-1:0] addr, output logic [WORD_W-1:0] data);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we  = 1'b0;
		wb_adr = addr;
		do begin
			@(posedge clk);
			#DRIVE_DLY;
		end while (!wb_ack);
		data   = wb_dat;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
	endtask

	task automatic load_job(input job_t j);
		wb_write(REG_BLOCK, j.block);
		wb_write(REG_IN_LO, j.cipher_in[31:0]);
		wb_write(REG_IN_HI, j.cipher_in[63:32]);
		wb_write(REG_MASK_LO, j.mask[31:0]);
		wb_write(REG_MASK_HI, j.mask[63:32]);
		wb_write(REG_VALUE_LO, j.value[31:0]);
		wb_write(REG_VALUE_HI, j.value[63:32]);
		wb_write(REG_TIMES_START, j.times_start);
		wb_write(REG_TIMES, j.times);
	endtask

	task automatic wait_idle();
		logic [WORD_W-1:0] st;
		repeat (2) @(posedge clk); // let the last push reach the queue
		#DRIVE_DLY;
		do begin
			wb_read(REG_DISPATCH, st);
		end while (st[3:2] != 2'b00);
	endtask

	task automatic expect_record(input int slot, input logic [3:0][WORD_W-1:0] exp);
		logic [WORD_W-1:0] rd;
		for (int w = 0; w < 4; w++) begin
			wb_read(RESULT_BASE + ADDR_W'(16 * slot + 4 * w), rd);
			check_eq($sformatf("wb_dat_o slot %0d word %0d", slot, w), exp[w], rd);
		end
	endtask

	task automatic register_access();
		logic [ADDR_W-1:0] addrs [9];
		logic [WORD_W-1:0] vals [9];
		logic [WORD_W-1:0] rd;
		addrs = '{REG_BLOCK, REG_IN_LO, REG_IN_HI, REG_MASK_LO, REG_MASK_HI,
			REG_VALUE_LO, REG_VALUE_HI, REG_TIMES_START, REG_TIMES};
		for (int i = 0; i < 9; i++) begin
			vals[i] = $urandom();
			wb_write(addrs[i], vals[i]);
		end
		for (int i = 0; i < 9; i++) begin
			wb_read(addrs[i], rd);
			check_eq($sformatf("wb_dat_o reg %h", addrs[i]), vals[i], rd);
		end
	endtask

	task automatic matching_search();
		job_t                   j;
		logic [WORD_W-1:0]      key;
		logic [3:0][WORD_W-1:0] exp;
		j             = random_job(3'd1);
		key           = $urandom();
		j.value       = mix_ref(j.cipher_in, key);
		j.times_start = key - 3; // match lands on the fourth candidate
		j.times       = 32'd10;
		load_job(j);
		wb_write(REG_DISPATCH, 32'd0);
		wait_idle();
		exp[0] = j.block;
		exp[1] = key;
		exp[2] = 32'h1;
		exp[3] = 32'd4;
		expect_record(1, exp);
	endtask

	task automatic no_match_and_zero();
		job_t                   j;
		logic [3:0][WORD_W-1:0] exp;
		j       = random_job(3'd2);
		j.times = 32'd300;
		j.value = mix_ref(j.cipher_in, j.times_start + 32'd1000);
		exp     = search_ref(j, 1'b0);
		check_eq("reference found flag", 32'h0, exp[2]);
		load_job(j);
		wb_write(REG_DISPATCH, 32'd0);
		wait_idle();
		exp[1] = '0;
		exp[3] = j.times;
		expect_record(2, exp);
		j       = random_job(3'd3);
		j.times = '0;
		load_job(j);
		wb_write(REG_DISPATCH, 32'd1);
		wait_idle();
		exp[0] = j.block;
		exp[1] = '0;
		exp[2] = 32'h2; // lane 1, not found
		exp[3] = '0;
		expect_record(3, exp);
	endtask

	task automatic both_lanes();
		job_t j0;
		job_t j1;
		j0       = random_job(3'd4);
		j0.mask  = 64'hff; // short mask so a match is likely
		j0.times = 32'd400;
		j1       = j0;
		j1.block = (j0.block & ~32'h7) | 32'd5;
		j1.times_start = j0.times_start + 32'd3;
		load_job(j0);
		wb_write(REG_DISPATCH, 32'd0);
		wb_write(REG_BLOCK, j1.block); // only two fields differ, so the lanes finish close together
		wb_write(REG_TIMES_START, j1.times_start);
		wb_write(REG_DISPATCH, 32'd1);
		wait_idle();
		expect_record(4, search_ref(j0, 1'b0));
		expect_record(5, search_ref(j1, 1'b1));
	endtask

	task automatic queue_backpressure();
		job_t              jobs [5];
		logic [SLOT_W-1:0] slots [5];
		logic [WORD_W-1:0] st;
		int                tries;
		slots = '{3'd4, 3'd5, 3'd4, 3'd6, 3'd5};
		for (int i = 0; i < 5; i++) begin
			jobs[i] = random_job(slots[i]);
			load_job(jobs[i]);
			wb_write(REG_DISPATCH, 32'd1);
		end
		tries = 0;
		do begin
			wb_read(REG_DISPATCH, st);
			tries++;
		end while (!st[1] && tries < 8);
		assert (st[1] && st[3]) else begin
			$display("Lane 1 did not report a full queue while its first job was running");
			$display("Test failed");
			$fatal(1, "queue status wrong");
		end
		wait_idle();
		expect_record(4, search_ref(jobs[2], 1'b1));
		expect_record(5, search_ref(jobs[4], 1'b1));
		expect_record(6, search_ref(jobs[3], 1'b1));
	endtask

	initial begin
		rst_n    = 1'b0;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = '0;
		wb_dat_w = '0;
		wb_sel   = 4'hf;
		void'($urandom(32'h18eae8b6));
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DLY;
		rst_n = 1'b1;
		register_access();
		matching_search();
		no_match_and_zero();
		both_lanes();
		queue_backpressure();
		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb/csa_search_asserts.sv
`default_nettype none

module csa_search_asserts (
	input wire clk,
	input wire rst_n,
	input wire wb_cyc_i,
	input wire wb_stb_i,
	input wire wb_ack_i,
	input wire gnt0_i,
	input wire gnt1_i
);

	int unsigned fail_count = 0;

	// ack answers a request seen on the previous edge
	ack_needs_request: assert property (@(posedge clk) disable iff (!rst_n)
		wb_ack_i |-> $past(wb_cyc_i & wb_stb_i))
		else begin
			fail_count++;
			$error("wishbone ack without cyc and stb");
		end

	ack_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		wb_ack_i |=> !wb_ack_i)
		else begin
			fail_count++;
			$error("wishbone ack high on two consecutive cycles");
		end

	grants_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(gnt0_i && gnt1_i))
		else begin
			fail_count++;
			$error("result store granted both lanes at once");
		end

endmodule

bind csa_search_top csa_search_asserts u_asserts (
	.clk      (clk),
	.rst_n    (rst_n),
	.wb_cyc_i (wb_cyc_i),
	.wb_stb_i (wb_stb_i),
	.wb_ack_i (wb_ack_o),
	.gnt0_i   (lane_if0.gnt),
	.gnt1_i   (lane_if1.gnt)
);

`default_nettype wire

//--- rtl/csa_search_top.sv
`default_nettype none

module csa_search_top import csa_pkg::*; (
	input  wire              clk,
	input  wire              rst_n,
	input  wire              wb_cyc_i,
	input  wire              wb_stb_i,
	input  wire              wb_we_i,
	input  wire [ADDR_W-1:0] wb_adr_i,
	input  wire [WORD_W-1:0] wb_dat_i,
	input  wire [3:0]        wb_sel_i,
	output logic [WORD_W-1:0] wb_dat_o,
	output logic             wb_ack_o
);

	logic [NUM_LANES-1:0] push;
	logic [NUM_LANES-1:0] full;
	logic [NUM_LANES-1:0] busy;
	job_t                 job;
	logic [SLOT_W-1:0]    rd_slot;
	result_word_u         rd_rec;

	lane_result_if lane_if0 ();
	lane_result_if lane_if1 ();

	wb_host_regs u_host (
		.clk       (clk),
		.rst_n     (rst_n),
		.wb_cyc_i  (wb_cyc_i),
		.wb_stb_i  (wb_stb_i),
		.wb_we_i   (wb_we_i),
		.wb_adr_i  (wb_adr_i),
		.wb_dat_i  (wb_dat_i),
		.wb_sel_i  (wb_sel_i),
		.wb_dat_o  (wb_dat_o),
		.wb_ack_o  (wb_ack_o),
		.push_o    (push),
		.job_o     (job),
		.full_i    (full),
		.busy_i    (busy),
		.rd_slot_o (rd_slot),
		.rd_rec_i  (rd_rec)
	);

	search_lane u_lane0 (
		.clk    (clk),
		.rst_n  (rst_n),
		.push_i (push[0]),
		.job_i  (job),
		.full_o (full[0]),
		.busy_o (busy[0]),
		.res    (lane_if0.lane)
	);

	search_lane u_lane1 (
		.clk    (clk),
		.rst_n  (rst_n),
		.push_i (push[1]),
		.job_i  (job),
		.full_o (full[1]),
		.busy_o (busy[1]),
		.res    (lane_if1.lane)
	);

	result_store u_store (
		.clk       (clk),
		.rst_n     (rst_n),
		.lane0     (lane_if0.store),
		.lane1     (lane_if1.store),
		.rd_slot_i (rd_slot),
		.rd_rec_o  (rd_rec)
	);

endmodule

`default_nettype wire

//--- rtl/wb_host_regs.sv
`default_nettype none

module wb_host_regs import csa_pkg::*; (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire                  wb_cyc_i,
	input  wire                  wb_stb_i,
	input  wire                  wb_we_i,
	input  wire [ADDR_W-1:0]     wb_adr_i,
	input  wire [WORD_W-1:0]     wb_dat_i,
	input  wire [3:0]            wb_sel_i, // byte lanes ignored, every access is a full word
	output logic [WORD_W-1:0]    wb_dat_o,
	output logic                 wb_ack_o,
	output logic [NUM_LANES-1:0] push_o,
	output job_t                 job_o,
	input  wire [NUM_LANES-1:0]  full_i,
	input  wire [NUM_LANES-1:0]  busy_i,
	output logic [SLOT_W-1:0]    rd_slot_o,
	input  wire result_word_u    rd_rec_i
);

	job_t              stage;
	logic              access;
	logic              wr;
	logic [ADDR_W-1:0] res_off;
	logic              in_results;
	logic [WORD_W-1:0] rd_data;

	assign access     = wb_cyc_i & wb_stb_i & ~wb_ack_o; // one access per ack
	assign wr         = access & wb_we_i;
	assign res_off    = wb_adr_i - RESULT_BASE;
	assign in_results = (wb_adr_i >= RESULT_BASE) && (res_off < ADDR_W'(RESULT_SLOTS * 16));
	assign rd_slot_o  = res_off[6:4];

	always_comb begin
		case (wb_adr_i)
			REG_BLOCK:       rd_data = stage.block;
			REG_IN_LO:       rd_data = stage.cipher_in[WORD_W-1:0];
			REG_IN_HI:       rd_data = stage.cipher_in[CIPHER_W-1:WORD_W];
			REG_MASK_LO:     rd_data = stage.mask[WORD_W-1:0];
			REG_MASK_HI:     rd_data = stage.mask[CIPHER_W-1:WORD_W];
			REG_VALUE_LO:    rd_data = stage.value[WORD_W-1:0];
			REG_VALUE_HI:    rd_data = stage.value[CIPHER_W-1:WORD_W];
			REG_TIMES_START: rd_data = stage.times_start;
			REG_TIMES:       rd_data = stage.times;
			REG_DISPATCH:    rd_data = {{(WORD_W-4){1'b0}}, busy_i, full_i};
			default: begin
				if (in_results)
					rd_data = rd_rec_i.words[res_off[3:2]];
				else
					rd_data = '0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_ack_o <= 1'b0;
			push_o   <= '0;
		end else begin
			wb_ack_o <= access;
			push_o   <= '0;
			if (wr && wb_adr_i == REG_DISPATCH && !full_i[wb_dat_i[0]])
				push_o[wb_dat_i[0]] <= 1'b1; // lands in the ack cycle
		end
	end

	always_ff @(posedge clk) begin
		if (access && !wb_we_i)
			wb_dat_o <= rd_data;
	end

	always_ff @(posedge clk) begin
		if (wr) begin
			case (wb_adr_i)
				REG_BLOCK:       stage.block <= wb_dat_i;
				REG_IN_LO:       stage.cipher_in[WORD_W-1:0] <= wb_dat_i;
				REG_IN_HI:       stage.cipher_in[CIPHER_W-1:WORD_W] <= wb_dat_i;
				REG_MASK_LO:     stage.mask[WORD_W-1:0] <= wb_dat_i;
				REG_MASK_HI:     stage.mask[CIPHER_W-1:WORD_W] <= wb_dat_i;
				REG_VALUE_LO:    stage.value[WORD_W-1:0] <= wb_dat_i;
				REG_VALUE_HI:    stage.value[CIPHER_W-1:WORD_W] <= wb_dat_i;
				REG_TIMES_START: stage.times_start <= wb_dat_i;
				REG_TIMES:       stage.times <= wb_dat_i;
				default:         stage <= stage;
			endcase
		end
	end

	assign job_o = stage;

endmodule

`default_nettype wire

//--- rtl/result_store.sv
`default_nettype none

module result_store import csa_pkg::*; (
	input  wire              clk,
	input  wire              rst_n,
	lane_result_if.store     lane0,
	lane_result_if.store     lane1,
	input  wire [SLOT_W-1:0] rd_slot_i,
	output result_word_u     rd_rec_o
);

	result_word_u mem [RESULT_SLOTS];
	logic         rr; // lane that wins the next tie
	logic         gnt0_q;
	logic         gnt1_q;
	logic         elig0;
	logic         elig1;
	logic         pick0;
	logic         pick1;

	// a lane in its grant cycle still shows req, so it sits that cycle out
	assign elig0 = lane0.req & ~gnt0_q;
	assign elig1 = lane1.req & ~gnt1_q;
	assign pick0 = elig0 & (~elig1 | ~rr);
	assign pick1 = elig1 & (~elig0 | rr);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rr     <= 1'b0;
			gnt0_q <= 1'b0;
			gnt1_q <= 1'b0;
		end else begin
			gnt0_q <= pick0;
			gnt1_q <= pick1;
			if (pick0)
				rr <= 1'b1;
			else if (pick1)
				rr <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < RESULT_SLOTS; i++) begin
				mem[i] <= '0;
			end
		end else begin
			if (gnt0_q)
				mem[lane0.slot] <= lane0.rec;
			if (gnt1_q)
				mem[lane1.slot] <= lane1.rec; // grants are exclusive
		end
	end

	assign lane0.gnt      = gnt0_q;
	assign lane1.gnt      = gnt1_q;
	assign lane0.lane_bit = 1'b0;
	assign lane1.lane_bit = 1'b1;
	assign rd_rec_o       = mem[rd_slot_i];

endmodule

`default_nettype wire

//--- rtl/search_lane.sv
`default_nettype none

module search_lane import csa_pkg::*; (
	input  wire       clk,
	input  wire       rst_n,
	input  wire       push_i,
	input  wire job_t job_i,
	output logic      full_o,
	output logic      busy_o,
	lane_result_if.lane res
);

	logic              fifo_ready;
	job_t              head;
	job_t              job_q;
	logic              pop;
	logic              pop_q;
	logic              start_q;
	logic              req_q;
	logic              done;
	logic              found;
	logic [WORD_W-1:0] key;
	logic [WORD_W-1:0] tried;
	logic              core_busy;
	result_word_u      rec;

	job_fifo u_fifo (
		.clk     (clk),
		.rst_n   (rst_n),
		.wr_en_i (push_i),
		.wdata_i (job_i),
		.full_o  (full_o),
		.rd_en_i (pop),
		.ready_o (fifo_ready),
		.rdata_o (head)
	);

	key_search_core u_core (
		.clk     (clk),
		.rst_n   (rst_n),
		.ready_i (fifo_ready),
		.pop_o   (pop),
		.stall_i (done | req_q), // no new job while a result waits for the store
		.start_i (start_q),
		.job_i   (job_q),
		.done_o  (done),
		.found_o (found),
		.key_o   (key),
		.tried_o (tried),
		.busy_o  (core_busy)
	);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pop_q   <= 1'b0;
			start_q <= 1'b0;
			req_q   <= 1'b0;
		end else begin
			pop_q   <= pop;
			start_q <= pop_q; // job_q has settled by now
			if (res.gnt)
				req_q <= 1'b0;
			else if (done)
				req_q <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (pop)
			job_q <= head;
	end

	always_comb begin
		rec.rec.block = job_q.block;
		rec.rec.key   = key;
		rec.rec.flags = {{(WORD_W-2){1'b0}}, res.lane_bit, found};
		rec.rec.tried = tried;
	end

	assign res.req  = req_q;
	assign res.slot = job_q.block[SLOT_W-1:0];
	assign res.rec  = rec;
	assign busy_o   = fifo_ready | core_busy | done | req_q;

endmodule

`default_nettype wire

//--- rtl/key_search_core.sv
`default_nettype none

module key_search_core import csa_pkg::*; (
	input  wire              clk,
	input  wire              rst_n,
	input  wire              ready_i,
	output logic             pop_o,
	input  wire              stall_i,
	input  wire              start_i,
	input  wire job_t        job_i,
	output logic             done_o,
	output logic             found_o,
	output logic [WORD_W-1:0] key_o,
	output logic [WORD_W-1:0] tried_o,
	output logic             busy_o
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WAIT,
		ST_RUN
	} state_t;

	state_t            state;
	logic [WORD_W-1:0] k;
	logic [WORD_W-1:0] cnt;
	logic [WORD_W-1:0] cnt_next;
	logic              hit;
	logic              last;

	function automatic logic [CIPHER_W-1:0] mix(input logic [CIPHER_W-1:0] in,
			input logic [WORD_W-1:0] cand);
		logic [CIPHER_W-1:0] s;
		s = in ^ {cand, ~cand};
		for (int r = 0; r < MIX_ROUNDS; r++) begin
			s = {s[CIPHER_W-12:0], s[CIPHER_W-1:CIPHER_W-11]} ^ (s >> 5) ^ MIX_CONST;
		end
		return s;
	endfunction

	assign hit      = (((mix(job_i.cipher_in, k) ^ job_i.value) & job_i.mask) == '0);
	assign cnt_next = cnt + 1'b1;
	assign last     = (cnt_next == job_i.times);
	assign busy_o   = (state != ST_IDLE);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state  <= ST_IDLE;
			pop_o  <= 1'b0;
			done_o <= 1'b0;
		end else begin
			pop_o  <= 1'b0;
			done_o <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (ready_i && !stall_i) begin
						pop_o <= 1'b1;
						state <= ST_WAIT;
					end
				end
				ST_WAIT: begin
					if (start_i) begin
						if (job_i.times == '0) begin // empty range finishes at once
							done_o <= 1'b1;
							state  <= ST_IDLE;
						end else begin
							state <= ST_RUN;
						end
					end
				end
				ST_RUN: begin
					if (hit || last) begin
						done_o <= 1'b1;
						state  <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// candidate datapath, results stay put until the next start
	always_ff @(posedge clk) begin
		if (state == ST_WAIT && start_i) begin
			k       <= job_i.times_start;
			cnt     <= '0;
			found_o <= 1'b0;
			key_o   <= '0;
			tried_o <= '0;
		end else if (state == ST_RUN) begin
			if (hit) begin
				found_o <= 1'b1;
				key_o   <= k;
				tried_o <= cnt_next;
			end else if (last) begin
				tried_o <= job_i.times;
			end else begin
				k   <= k + 1'b1;
				cnt <= cnt_next;
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/job_fifo.sv
`default_nettype none

module job_fifo import csa_pkg::*; (
	input  wire       clk,
	input  wire       rst_n,
	input  wire       wr_en_i,
	input  wire job_t wdata_i,
	output logic      full_o,
	input  wire       rd_en_i,
	output logic      ready_o,
	output job_t      rdata_o
);

	job_t                  mem [FIFO_DEPTH];
	logic [FIFO_PTR_W-1:0] wr_ptr;
	logic [FIFO_PTR_W-1:0] rd_ptr;
	logic [FIFO_PTR_W:0]   count;
	logic                  do_wr;
	logic                  do_rd;

	assign full_o  = (count == (FIFO_PTR_W+1)'(FIFO_DEPTH));
	assign ready_o = (count != '0);
	assign do_wr   = wr_en_i & ~full_o; // a push into a full queue is dropped
	assign do_rd   = rd_en_i & ready_o;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1; // depth is a power of two, so it wraps
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= wdata_i;
	end

	assign rdata_o = mem[rd_ptr]; // head of queue, valid while ready_o

endmodule

`default_nettype wire

//--- rtl/lane_result_if.sv
`default_nettype none

interface lane_result_if import csa_pkg::*; ();

	logic              req;
	logic              gnt;
	logic [SLOT_W-1:0] slot;
	result_word_u      rec;
	logic              lane_bit; // tied off by the store, one value per port

	modport lane (
		output req, slot, rec,
		input  gnt, lane_bit
	);

	modport store (
		input  req, slot, rec,
		output gnt, lane_bit
	);

endinterface

`default_nettype wire

//--- rtl/csa_pkg.sv
`default_nettype none

package csa_pkg;

	localparam int WORD_W       = 32;
	localparam int CIPHER_W     = 64;
	localparam int NUM_LANES    = 2;
	localparam int FIFO_DEPTH   = 4;
	localparam int FIFO_PTR_W   = $clog2(FIFO_DEPTH);
	localparam int RESULT_SLOTS = 8;
	localparam int SLOT_W       = $clog2(RESULT_SLOTS);
	localparam int ADDR_W       = 8;

	localparam logic [CIPHER_W-1:0] MIX_CONST = 64'h9e3779b97f4a7c15;
	localparam int MIX_ROUNDS = 4;

	// host register map, byte addresses
	localparam logic [ADDR_W-1:0] REG_BLOCK       = 8'h00;
	localparam logic [ADDR_W-1:0] REG_IN_LO       = 8'h04;
	localparam logic [ADDR_W-1:0] REG_IN_HI       = 8'h08;
	localparam logic [ADDR_W-1:0] REG_MASK_LO     = 8'h0C;
	localparam logic [ADDR_W-1:0] REG_MASK_HI     = 8'h10;
	localparam logic [ADDR_W-1:0] REG_VALUE_LO    = 8'h14;
	localparam logic [ADDR_W-1:0] REG_VALUE_HI    = 8'h18;
	localparam logic [ADDR_W-1:0] REG_TIMES_START = 8'h1C;
	localparam logic [ADDR_W-1:0] REG_TIMES       = 8'h20;
	localparam logic [ADDR_W-1:0] REG_DISPATCH    = 8'h24;
	localparam logic [ADDR_W-1:0] RESULT_BASE     = 8'h40;

	typedef struct packed {
		logic [WORD_W-1:0]   block;
		logic [CIPHER_W-1:0] cipher_in;
		logic [CIPHER_W-1:0] mask;
		logic [CIPHER_W-1:0] value;
		logic [WORD_W-1:0]   times_start;
		logic [WORD_W-1:0]   times;
	} job_t;

	// word 0 sits in the low bits, so the struct lists word 3 first
	typedef struct packed {
		logic [WORD_W-1:0] tried;
		logic [WORD_W-1:0] flags; // bit 0 found, bit 1 lane
		logic [WORD_W-1:0] key;
		logic [WORD_W-1:0] block;
	} result_rec_t;

	typedef union packed {
		result_rec_t             rec;
		logic [3:0][WORD_W-1:0]  words;
	} result_word_u;

endpackage

`default_nettype wire
